// ==== build.sh ====
#!/bin/sh
# Compile and run the gb_system testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module gb_system_tb -f gb_system.f -o gb_system_sim

./obj_dir/gb_system_sim > sim.log
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0

// ==== common/gb_pkg.sv ====
package gb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// First-bank opcodes known to the decoder.
	// Anything else in bank 0 runs as a NOP.
	typedef enum logic [7:0] {
		op_nop       = 8'h00,
		op_ld_a_d8   = 8'h3e,
		op_halt      = 8'h76,
		op_jp_a16    = 8'hc3,
		op_prefix_cb = 8'hcb,
		op_ld_a16_a  = 8'hea
	} opcode_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One state per machine cycle kind.
	typedef enum logic [2:0] {
		st_ifetch,
		st_imml_fetch,
		st_immh_fetch,
		st_execute,
		st_write,
		st_halted
	} seq_state_e;

	// Instruction descriptor from the decoder.
	// Dummy machine cycles come after all fetch and write cycles.
	typedef struct packed {
		logic [1:0] imm_bytes;
		logic [1:0] dummy_mcycles;
		logic       is_jump;
		logic       is_load_a;
		logic       is_store;
		logic       is_halt;
		logic       set_bank;
	} instr_desc_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus observation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One event per read or write strobe.
	// Data is the byte read from memory or the byte written to it.
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [15:0] adr;
		logic [7:0]  data;
	} bus_event_t;

endpackage

// ==== cpu/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
	parameter int          MEM_ADR_BITS = 10,
	parameter logic [15:0] RESET_PC     = 16'h0000
) (
	input  logic        clk,
	input  logic        reset,
	output logic [15:0] adr,
	input  logic [7:0]  data,
	output logic [7:0]  dout,
	output logic        ddrv,
	output logic        read,
	output logic        write,
	output logic        halted,
	output logic [7:0]  dbg_op
);

	import gb_pkg::*;

	// PC steps wrap inside the memory window, upper bits stay put.
	localparam logic [15:0] PC_WRAP_MASK = 16'((32'd1 << MEM_ADR_BITS) - 32'd1);

	seq_state_e  state, state_nx;
	seq_state_e  after_fetch;
	logic [1:0]  cycle, cycle_nx;
	logic [1:0]  dummy_cnt, dummy_cnt_nx;

	logic [7:0]  op, op_nx;
	logic        bank, bank_nx;
	logic        bank_clr, bank_clr_nx;
	logic [7:0]  imml, imml_nx;
	logic [7:0]  immh, immh_nx;

	logic [15:0] pc, pc_nx, pc_inc;
	logic [7:0]  a, a_nx;

	logic [15:0] adr_nx;
	logic [7:0]  dout_nx;
	logic        ddrv_nx;
	logic        read_nx;
	logic        write_nx;

	instr_desc_t desc;

	cpu_decode cpu_decode_inst (
		.bank (bank),
		.op   (op),
		.desc (desc)
	);

	assign pc_inc = (pc & ~PC_WRAP_MASK) | ((pc + 16'd1) & PC_WRAP_MASK);
	assign halted = (state == st_halted);
	assign dbg_op = op;

	// Where to go once all immediates are in.
	always_comb
	begin
		if (desc.is_store)
			after_fetch = st_write;
		else if (desc.dummy_mcycles != 2'd0)
			after_fetch = st_execute;
		else
			after_fetch = st_ifetch;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		state_nx     = state;
		cycle_nx     = cycle + 2'd1;
		dummy_cnt_nx = dummy_cnt;
		op_nx        = op;
		bank_nx      = bank;
		bank_clr_nx  = bank_clr;
		imml_nx      = imml;
		immh_nx      = immh;
		pc_nx        = pc;
		a_nx         = a;
		adr_nx       = adr;
		dout_nx      = dout;
		ddrv_nx      = ddrv;
		read_nx      = read;
		write_nx     = write;

		case (state)
		st_ifetch, st_imml_fetch, st_immh_fetch:
		begin
			case (cycle)
			// Read request from the PC.
			2'd0:
			begin
				adr_nx  = pc;
				read_nx = 1'b1;
				// Bank 1 lasts for exactly one opcode.
				if (state == st_ifetch && bank_clr)
				begin
					bank_nx     = 1'b0;
					bank_clr_nx = 1'b0;
				end
			end
			// Capture the byte and step the PC.
			2'd1:
			begin
				read_nx = 1'b0;
				pc_nx   = pc_inc;
				if (state == st_ifetch)
					op_nx = data;
				else if (state == st_imml_fetch)
				begin
					imml_nx = data;
					if (desc.is_load_a)
						a_nx = data;
				end
				else
					immh_nx = data;
			end
			2'd3:
			begin
				if (state == st_ifetch)
				begin
					dummy_cnt_nx = desc.dummy_mcycles;
					if (desc.set_bank)
						bank_nx = 1'b1;
					else if (bank)
						bank_clr_nx = 1'b1;

					if (desc.is_halt)
						state_nx = st_halted;
					else if (desc.imm_bytes != 2'd0)
						state_nx = st_imml_fetch;
					else
						state_nx = after_fetch;
				end
				else if (state == st_imml_fetch && desc.imm_bytes == 2'd2)
					state_nx = st_immh_fetch;
				else
					state_nx = after_fetch;
			end
			default:
			begin
				state_nx = state;
			end
			endcase
		end

		// Store A at the immediate address.
		st_write:
		begin
			case (cycle)
			2'd0:
			begin
				adr_nx   = {immh, imml};
				dout_nx  = a;
				write_nx = 1'b1;
				ddrv_nx  = 1'b1;
			end
			2'd1:
			begin
				write_nx = 1'b0;
				ddrv_nx  = 1'b0;
			end
			2'd3:
			begin
				state_nx = (dummy_cnt != 2'd0) ? st_execute : st_ifetch;
			end
			default:
			begin
				write_nx = write;
			end
			endcase
		end

		// Dummy machine cycles, the jump lands on the last one.
		st_execute:
		begin
			if (cycle == 2'd3)
			begin
				dummy_cnt_nx = dummy_cnt - 2'd1;
				if (dummy_cnt == 2'd1)
				begin
					if (desc.is_jump)
						pc_nx = {immh, imml};
					state_nx = st_ifetch;
				end
			end
		end

		// No more bus traffic.
		default:
		begin
			state_nx = st_halted;
		end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		adr  <= adr_nx;
		dout <= dout_nx;
		op   <= op_nx;
		imml <= imml_nx;
		immh <= immh_nx;

		if (reset)
		begin
			state     <= st_ifetch;
			cycle     <= 2'd0;
			dummy_cnt <= 2'd0;
			bank      <= 1'b0;
			bank_clr  <= 1'b0;
			pc        <= RESET_PC;
			a         <= 8'h00;
			ddrv      <= 1'b0;
			read      <= 1'b0;
			write     <= 1'b0;
		end
		else
		begin
			state     <= state_nx;
			cycle     <= cycle_nx;
			dummy_cnt <= dummy_cnt_nx;
			bank      <= bank_nx;
			bank_clr  <= bank_clr_nx;
			pc        <= pc_nx;
			a         <= a_nx;
			ddrv      <= ddrv_nx;
			read      <= read_nx;
			write     <= write_nx;
		end
	end

endmodule

// ==== cpu/cpu_decode.sv ====
`timescale 1ns/1ps

module cpu_decode (
	input  logic                bank,
	input  logic [7:0]          op,
	output gb_pkg::instr_desc_t desc
);

	import gb_pkg::*;

	opcode_e opcode;

	assign opcode = opcode_e'(op);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Default is a one machine cycle no-op.
	// The second bank has nothing implemented, so only bank 0 is decoded.
	always_comb
	begin
		desc = '0;
		if (!bank)
		begin
			case (opcode)
			// PREFIX CB (1,4): next opcode comes from bank 1.
			op_prefix_cb:
			begin
				desc.set_bank = 1'b1;
			end
			// JP a16 (3,16): two immediates, one cycle to load the PC.
			op_jp_a16:
			begin
				desc.imm_bytes     = 2'd2;
				desc.dummy_mcycles = 2'd1;
				desc.is_jump       = 1'b1;
			end
			// LD A,d8 (2,8).
			op_ld_a_d8:
			begin
				desc.imm_bytes = 2'd1;
				desc.is_load_a = 1'b1;
			end
			// LD (a16),A (3,16): the fourth cycle is the write.
			op_ld_a16_a:
			begin
				desc.imm_bytes = 2'd2;
				desc.is_store  = 1'b1;
			end
			// HALT stops fetching for good.
			op_halt:
			begin
				desc.is_halt = 1'b1;
			end
			default:
			begin
				desc = '0;
			end
			endcase
		end
	end

endmodule

// ==== gb_system.f ====
+incdir+verif
common/gb_pkg.sv
cpu/cpu_decode.sv
cpu/cpu_core.sv
logic/gb_memory.sv
logic/gb_system.sv
verif/gb_system_tb.sv

// ==== logic/gb_memory.sv ====
`timescale 1ns/1ps

module gb_memory #(
	parameter int MEM_ADR_BITS = 10
) (
	input  logic               clk,
	input  logic [15:0]        adr,
	input  logic [7:0]         dout,
	input  logic               ddrv,
	input  logic               read,
	input  logic               write,
	output logic [7:0]         data,
	input  logic               load_en,
	input  logic [15:0]        load_adr,
	input  logic [7:0]         load_data,
	output gb_pkg::bus_event_t event_out
);

	import gb_pkg::*;

	localparam int MEM_WORDS = 2 ** MEM_ADR_BITS;

	logic [7:0]              mem [MEM_WORDS];
	logic [MEM_ADR_BITS-1:0] word_adr;
	logic [MEM_ADR_BITS-1:0] load_word_adr;
	bus_event_t              bus_event;

	// High address bits are ignored, so the RAM aliases.
	assign word_adr      = adr[MEM_ADR_BITS-1:0];
	assign load_word_adr = load_adr[MEM_ADR_BITS-1:0];

	// Asynchronous read.
	assign data = mem[word_adr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The load port only runs while the core is held in reset.
	always_ff @(posedge clk)
	begin
		if (load_en)
			mem[load_word_adr] <= load_data;
		else if (write && ddrv)
			mem[word_adr] <= dout;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus events
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Same clock as the strobe.
	always_comb
	begin
		bus_event.valid = read || write;
		bus_event.write = write;
		bus_event.adr   = adr;
		bus_event.data  = write ? dout : data;
	end

	assign event_out = bus_event;

endmodule

// ==== logic/gb_system.sv ====
`timescale 1ns/1ps

module gb_system #(
	parameter int          MEM_ADR_BITS = 10,
	parameter logic [15:0] RESET_PC     = 16'h0000
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               load_en,
	input  logic [15:0]        load_adr,
	input  logic [7:0]         load_data,
	output gb_pkg::bus_event_t event_out,
	output logic               halted,
	output logic [7:0]         dbg_op
);

	// Core to memory bus.
	logic [15:0] adr;
	logic [7:0]  rd_data;
	logic [7:0]  wr_data;
	logic        ddrv;
	logic        read;
	logic        write;

	cpu_core #(
		.MEM_ADR_BITS (MEM_ADR_BITS),
		.RESET_PC     (RESET_PC)
	) cpu_core_inst (
		.clk    (clk),
		.reset  (reset),
		.adr    (adr),
		.data   (rd_data),
		.dout   (wr_data),
		.ddrv   (ddrv),
		.read   (read),
		.write  (write),
		.halted (halted),
		.dbg_op (dbg_op)
	);

	gb_memory #(
		.MEM_ADR_BITS (MEM_ADR_BITS)
	) gb_memory_inst (
		.clk       (clk),
		.adr       (adr),
		.dout      (wr_data),
		.ddrv      (ddrv),
		.read      (read),
		.write     (write),
		.data      (rd_data),
		.load_en   (load_en),
		.load_adr  (load_adr),
		.load_data (load_data),
		.event_out (event_out)
	);

endmodule

// ==== verif/gb_model.svh ====
`ifndef GB_MODEL_SVH
`define GB_MODEL_SVH

// One expected bus access and the clock edge that completes it.
typedef struct packed {
	logic        write;
	logic        is_op;
	logic [15:0] adr;
	logic [7:0]  data;
	logic [31:0] clk_no;
} exp_event_t;

exp_event_t  exp_q[$];
logic [7:0]  model_mem [2 ** MEM_ADR_BITS];
logic [15:0] model_pc;
logic [7:0]  model_a;
logic [31:0] model_clk;

// High address bits alias onto the RAM.
function automatic int word_of(input logic [15:0] adr);
	return int'(adr[MEM_ADR_BITS-1:0]);
endfunction

// Each access fills one machine cycle of four clocks.
function automatic void push_event(
	input logic        write,
	input logic        is_op,
	input logic [15:0] adr,
	input logic [7:0]  data
);
	exp_event_t ev;
	ev.write  = write;
	ev.is_op  = is_op;
	ev.adr    = adr;
	ev.data   = data;
	ev.clk_no = model_clk;
	exp_q.push_back(ev);
	model_clk = model_clk + 32'd4;
endfunction

function automatic logic [7:0] fetch_byte(input logic is_op);
	logic [7:0] b;
	b = model_mem[word_of(model_pc)];
	push_event(1'b0, is_op, model_pc, b);
	model_pc = model_pc + 16'd1;
	return b;
endfunction

// Walks the image from RESET_PC up to HALT.
function automatic void run_model();
	logic [7:0] op;
	logic [7:0] lo;
	logic [7:0] hi;
	logic       bank;
	logic       done;
	int         i;

	for (i = 0; i < IMG_BYTES; i++)
		model_mem[word_of(RESET_PC + 16'(i))] = image[i];
	exp_q.delete();
	model_pc  = RESET_PC;
	model_a   = 8'h00;
	model_clk = 32'd2;
	bank      = 1'b0;
	done      = 1'b0;

	for (i = 0; i < 2 * IMG_BYTES && !done; i++)
	begin
		op = fetch_byte(1'b1);
		// Second bank opcodes are all plain no-ops.
		if (bank)
			bank = 1'b0;
		else
		begin
			case (op)
			op_prefix_cb:
				bank = 1'b1;
			op_ld_a_d8:
				model_a = fetch_byte(1'b0);
			op_jp_a16:
			begin
				lo = fetch_byte(1'b0);
				hi = fetch_byte(1'b0);
				// Extra machine cycle to load the PC.
				model_clk = model_clk + 32'd4;
				model_pc  = {hi, lo};
			end
			op_ld_a16_a:
			begin
				lo = fetch_byte(1'b0);
				hi = fetch_byte(1'b0);
				push_event(1'b1, 1'b0, {hi, lo}, model_a);
				model_mem[word_of({hi, lo})] = model_a;
			end
			op_halt:
				done = 1'b1;
			default:
				done = 1'b0;
			endcase
		end
	end
endfunction

`endif

// ==== verif/gb_system_tb.sv ====
`timescale 1ns/1ps

module gb_system_tb;

	import gb_pkg::*;

	localparam int          MEM_ADR_BITS = 10;
	localparam logic [15:0] RESET_PC     = 16'h0100;
	localparam int          RESET_CYCLES = 16;
	// One image byte goes in per reset clock.
	localparam int          IMG_BYTES    = RESET_CYCLES;
	localparam int          PREFIX_BYTES = 8;
	localparam int          NUM_PROGRAMS = 12;
	localparam int          HALT_TIMEOUT = 1000;
	localparam int          QUIET_CLKS   = 200;
	localparam logic [31:0] SEED         = 32'd46;

	logic        clk;
	logic        reset;
	logic        load_en;
	logic [15:0] load_adr;
	logic [7:0]  load_data;
	bus_event_t  event_out;
	logic        halted;
	logic [7:0]  dbg_op;

	logic [7:0]  image [IMG_BYTES];
	logic [31:0] rng_state;
	logic [31:0] clk_no;
	logic        running;
	logic        op_pending = 1'b0;
	logic [7:0]  op_expected;
	int          mismatches = 0;
	int          timeouts = 0;

	`include "gb_model.svh"

	gb_system #(
		.MEM_ADR_BITS (MEM_ADR_BITS),
		.RESET_PC     (RESET_PC)
	) gb_system_inst (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_adr  (load_adr),
		.load_data (load_data),
		.event_out (event_out),
		.halted    (halted),
		.dbg_op    (dbg_op)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return {8'd0, rng_state[31:8]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	// Random prefix, then a load, a store into the next immediate, its readback and HALT.
	task automatic make_program();
		int          kinds [PREFIX_BYTES];
		int          starts [PREFIX_BYTES + 1];
		int          n;
		int          len;
		int          size;
		int          p;
		int          i;
		logic [31:0] r;
		logic [15:0] target;

		n   = 0;
		len = 0;
		while (len < PREFIX_BYTES)
		begin
			kinds[n] = int'(next_random() % 32'd5);
			size     = (kinds[n] == 0) ? 1 : (kinds[n] <= 2) ? 2 : 3;
			if (len + size > PREFIX_BYTES)
			begin
				kinds[n] = 0;
				size     = 1;
			end
			starts[n] = len;
			n++;
			len += size;
		end
		starts[n] = len;
		for (i = 0; i < IMG_BYTES; i++)
			image[i] = 8'h00;

		for (i = 0; i < n; i++)
		begin
			p = starts[i];
			r = next_random();
			case (kinds[i])
			1:
			begin
				image[p] = op_prefix_cb;
				// Jump and store must stay inert in the second bank.
				if (r[1:0] == 2'd0)
					image[p + 1] = op_jp_a16;
				else if (r[1:0] == 2'd1)
					image[p + 1] = op_ld_a16_a;
				else
					image[p + 1] = r[15:8];
			end
			2:
			begin
				image[p]     = op_ld_a_d8;
				image[p + 1] = r[7:0];
			end
			3:
			begin
				// Bit 9 set keeps it above the code and the high bits alias.
				target       = {r[21:16], 1'b1, r[8:0]};
				image[p]     = op_ld_a16_a;
				image[p + 1] = target[7:0];
				image[p + 2] = target[15:8];
			end
			4:
			begin
				target       = RESET_PC + 16'(starts[i + 1 + int'(r % 32'(n - i))]);
				image[p]     = op_jp_a16;
				image[p + 1] = target[7:0];
				image[p + 2] = target[15:8];
			end
			default:
				image[p] = op_nop;
			endcase
		end

		r            = next_random();
		target       = RESET_PC + 16'(len + 6);
		image[len]     = op_ld_a_d8;
		image[len + 1] = r[7:0];
		image[len + 2] = op_ld_a16_a;
		image[len + 3] = target[7:0];
		image[len + 4] = target[15:8];
		image[len + 5] = op_ld_a_d8;
		image[len + 6] = r[15:8];
		image[len + 7] = op_halt;
	endtask

	task automatic reset_and_load();
		int i;
		for (i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge clk);
			reset     = 1'b1;
			load_en   = 1'b1;
			load_adr  = RESET_PC + 16'(i);
			load_data = image[i];
		end
		@(negedge clk);
		reset   = 1'b0;
		load_en = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Clock count since the last reset edge.
	always @(posedge clk)
	begin
		if (reset)
		begin
			clk_no  <= 32'd0;
			running <= 1'b0;
		end
		else
		begin
			clk_no  <= clk_no + 32'd1;
			running <= 1'b1;
		end
	end

	always @(negedge clk)
	begin
		exp_event_t ev;
		if (op_pending)
		begin
			check_value("opcode register", 32'(dbg_op), 32'(op_expected));
			op_pending = 1'b0;
		end
		if (running && event_out.valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected bus access at %0t ns to address %h", $time,
					event_out.adr);
				mismatches++;
			end
			else
			begin
				ev = exp_q.pop_front();
				check_value("event write flag", 32'(event_out.write), 32'(ev.write));
				check_value("event address", 32'(event_out.adr), 32'(ev.adr));
				check_value("event data", 32'(event_out.data), 32'(ev.data));
				// The access completes at the next rising edge.
				check_value("event clock", clk_no + 32'd1, ev.clk_no);
				// The opcode is latched at the end of its fetch clock.
				if (ev.is_op)
				begin
					op_pending  = 1'b1;
					op_expected = ev.data;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		int prog;
		int waited;
		int i;

		reset     = 1'b1;
		load_en   = 1'b0;
		load_adr  = 16'h0000;
		load_data = 8'h00;
		rng_state = SEED;

		for (prog = 0; prog < NUM_PROGRAMS; prog++)
		begin
			make_program();
			run_model();
			$display("Program %0d: %0d bus accesses expected", prog, exp_q.size());
			reset_and_load();

			@(negedge clk);
			check_value("halted after reset", 32'(halted), 32'd0);

			waited = 0;
			while (halted !== 1'b1 && waited < HALT_TIMEOUT)
			begin
				@(negedge clk);
				waited++;
			end
			if (halted !== 1'b1)
			begin
				$display("Timeout: program %0d did not reach HALT within %0d clocks",
					prog, HALT_TIMEOUT);
				timeouts++;
			end

			// Any access in this window is flagged by the monitor.
			for (i = 0; i < QUIET_CLKS; i++)
				@(negedge clk);
			check_value("halted after quiet period", 32'(halted), 32'd1);
			check_value("expected accesses left", 32'(exp_q.size()), 32'd0);
		end

		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
